// File: Bender.yml
package:
  name: mips_multicycle

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mips_pkg.sv
      - design/alu.sv
      - design/reg_file.sv
      - design/control_fsm.sv
      - design/datapath.sv
      - design/mips_cpu.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/mips_checker.sv
      - testbench/tb_mips_cpu.sv

// File: design/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_cfg.svh"

module alu (
    input  wire logic [`MIPS_DATA_WIDTH-1:0] x,
    input  wire logic [`MIPS_DATA_WIDTH-1:0] y,
    input  wire mips_pkg::alu_op_t           op,
    output logic [`MIPS_DATA_WIDTH-1:0]      z,
    output logic                             zero
);

    logic less; // Signed compare for slt

    assign less = $signed(x) < $signed(y);

    always_comb begin
        case (op)
            mips_pkg::alu_sub: z = x - y;
            mips_pkg::alu_and: z = x & y;
            mips_pkg::alu_or:  z = x | y;
            mips_pkg::alu_slt: z = {{(`MIPS_DATA_WIDTH-1){1'b0}}, less};
            default:           z = x + y; // Add for R-type, PC+4 and address math
        endcase
    end

    // Drives beq/bne after a subtract
    assign zero = (z == '0);

endmodule

`default_nettype wire

// File: design/control_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module control_fsm (
    input  wire logic              clk,
    input  wire logic              clk_en,
    input  wire logic              reset,
    input  wire mips_pkg::opcode_t opcode,
    input  wire mips_pkg::funct_t  funct,
    output logic                   pc_write,
    output logic                   branch_eq,
    output logic                   branch_ne,
    output logic                   iord,
    output logic                   ir_write,
    output logic                   mdr_write,
    output logic                   alu_out_write,
    output logic                   reg_write,
    output logic                   reg_dst,
    output logic                   mem_to_reg,
    output logic                   alu_src_a,
    output mips_pkg::src_b_t       alu_src_b,
    output mips_pkg::pc_src_t      pc_src,
    output mips_pkg::alu_op_t      alu_op,
    output logic                   wr_en
);

    mips_pkg::state_t  state;
    mips_pkg::state_t  next_state;
    mips_pkg::alu_op_t r_alu_op; // Operation picked by funct

    // State only moves on enabled cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::st_fetch;
        end else if (clk_en) begin
            state <= next_state;
        end
    end

    always_comb begin
        case (funct)
            mips_pkg::fn_sub: r_alu_op = mips_pkg::alu_sub;
            mips_pkg::fn_and: r_alu_op = mips_pkg::alu_and;
            mips_pkg::fn_or:  r_alu_op = mips_pkg::alu_or;
            mips_pkg::fn_slt: r_alu_op = mips_pkg::alu_slt;
            default:          r_alu_op = mips_pkg::alu_add; // fn_add and anything unknown
        endcase
    end

    // Strobe is qualified by clk_en so each sw writes memory once
    assign wr_en = (state == mips_pkg::st_mem_write) && clk_en;

    always_comb begin
        next_state    = mips_pkg::st_fetch;
        pc_write      = 1'b0;
        branch_eq     = 1'b0;
        branch_ne     = 1'b0;
        iord          = 1'b0; // PC drives the address by default
        ir_write      = 1'b0;
        mdr_write     = 1'b0;
        alu_out_write = 1'b0;
        reg_write     = 1'b0;
        reg_dst       = 1'b0;
        mem_to_reg    = 1'b0;
        alu_src_a     = 1'b0;
        alu_src_b     = mips_pkg::src_b_reg_b;
        pc_src        = mips_pkg::pc_alu_result;
        alu_op        = mips_pkg::alu_add;
        case (state)
            mips_pkg::st_fetch: begin
                // Latch instruction and step PC by four in the same cycle
                ir_write   = 1'b1;
                alu_src_b  = mips_pkg::src_b_four;
                pc_write   = 1'b1;
                next_state = mips_pkg::st_decode;
            end
            mips_pkg::st_decode: begin
                // Branch target computed speculatively from PC+4
                alu_src_b     = mips_pkg::src_b_imm_shifted;
                alu_out_write = 1'b1;
                case (opcode)
                    mips_pkg::op_lw,
                    mips_pkg::op_sw:    next_state = mips_pkg::st_mem_addr;
                    mips_pkg::op_rtype: next_state = mips_pkg::st_r_execute;
                    mips_pkg::op_beq,
                    mips_pkg::op_bne:   next_state = mips_pkg::st_branch;
                    mips_pkg::op_addi:  next_state = mips_pkg::st_imm_execute;
                    mips_pkg::op_j:     next_state = mips_pkg::st_jump;
                    default:            next_state = mips_pkg::st_fetch;
                endcase
            end
            mips_pkg::st_mem_addr: begin
                alu_src_a     = 1'b1;
                alu_src_b     = mips_pkg::src_b_imm;
                alu_out_write = 1'b1; // Effective address
                next_state    = (opcode == mips_pkg::op_lw) ? mips_pkg::st_mem_read
                                                            : mips_pkg::st_mem_write;
            end
            mips_pkg::st_mem_read: begin
                iord       = 1'b1;
                mdr_write  = 1'b1;
                next_state = mips_pkg::st_mem_writeback;
            end
            mips_pkg::st_mem_writeback: begin
                mem_to_reg = 1'b1; // rt gets the loaded word
                reg_write  = 1'b1;
            end
            mips_pkg::st_mem_write: begin
                iord = 1'b1; // Address from ALU-out and data from B
            end
            mips_pkg::st_r_execute: begin
                alu_src_a     = 1'b1;
                alu_op        = r_alu_op;
                alu_out_write = 1'b1;
                next_state    = mips_pkg::st_r_writeback;
            end
            mips_pkg::st_r_writeback: begin
                reg_dst   = 1'b1; // rd
                reg_write = 1'b1;
            end
            mips_pkg::st_branch: begin
                // Compare rs and rt while the target sits in ALU-out
                alu_src_a = 1'b1;
                alu_op    = mips_pkg::alu_sub;
                pc_src    = mips_pkg::pc_alu_out;
                branch_eq = (opcode == mips_pkg::op_beq);
                branch_ne = (opcode == mips_pkg::op_bne);
            end
            mips_pkg::st_imm_execute: begin
                alu_src_a     = 1'b1;
                alu_src_b     = mips_pkg::src_b_imm;
                alu_out_write = 1'b1;
                next_state    = mips_pkg::st_imm_writeback;
            end
            mips_pkg::st_imm_writeback: begin
                reg_write = 1'b1; // rt
            end
            mips_pkg::st_jump: begin
                pc_src   = mips_pkg::pc_jump_target;
                pc_write = 1'b1;
            end
            default: begin
                next_state = mips_pkg::st_fetch;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/datapath.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_cfg.svh"

module datapath (
    input  wire logic                            clk,
    input  wire logic                            clk_en,
    input  wire logic                            reset,
    input  wire logic                            pc_write,
    input  wire logic                            branch_eq,
    input  wire logic                            branch_ne,
    input  wire logic                            iord,
    input  wire logic                            ir_write,
    input  wire logic                            mdr_write,
    input  wire logic                            alu_out_write,
    input  wire logic                            reg_dst,
    input  wire logic                            mem_to_reg,
    input  wire logic                            alu_src_a,
    input  wire mips_pkg::src_b_t                alu_src_b,
    input  wire mips_pkg::pc_src_t               pc_src,
    input  wire logic [`MIPS_DATA_WIDTH-1:0]     r_data,
    input  wire logic [`MIPS_DATA_WIDTH-1:0]     rf_r0_data,
    input  wire logic [`MIPS_DATA_WIDTH-1:0]     rf_r1_data,
    input  wire logic [`MIPS_DATA_WIDTH-1:0]     alu_result,
    input  wire logic                            alu_zero,
    output mips_pkg::opcode_t                    opcode,
    output mips_pkg::funct_t                     funct,
    output logic [`MIPS_DATA_WIDTH-1:0]          mem_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]          w_data,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0]      rf_r0_addr,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0]      rf_r1_addr,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0]      rf_w_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]          rf_w_data,
    output logic [`MIPS_DATA_WIDTH-1:0]          alu_x,
    output logic [`MIPS_DATA_WIDTH-1:0]          alu_y
);

    logic [`MIPS_DATA_WIDTH-1:0] pc;
    logic [`MIPS_DATA_WIDTH-1:0] ir;          // Instruction register
    logic [`MIPS_DATA_WIDTH-1:0] mdr;         // Loaded data word
    logic [`MIPS_DATA_WIDTH-1:0] a_reg;       // rs value
    logic [`MIPS_DATA_WIDTH-1:0] b_reg;       // rt value
    logic [`MIPS_DATA_WIDTH-1:0] alu_out;
    logic [`MIPS_DATA_WIDTH-1:0] sign_imm;
    logic [`MIPS_DATA_WIDTH-1:0] imm_shifted;
    logic [`MIPS_DATA_WIDTH-1:0] jump_target;
    logic [`MIPS_DATA_WIDTH-1:0] pc_next;
    logic                        take_branch;
    logic                        pc_en;

    // Instruction fields
    assign opcode     = mips_pkg::opcode_t'(ir[31:26]);
    assign funct      = mips_pkg::funct_t'(ir[5:0]);
    assign rf_r0_addr = ir[25:21];
    assign rf_r1_addr = ir[20:16];
    assign rf_w_addr  = reg_dst ? ir[15:11] : ir[20:16]; // rd for R-type, else rt

    assign sign_imm    = {{(`MIPS_DATA_WIDTH-16){ir[15]}}, ir[15:0]};
    assign imm_shifted = {sign_imm[`MIPS_DATA_WIDTH-3:0], 2'b00}; // Word offset to bytes
    assign jump_target = {pc[`MIPS_DATA_WIDTH-1 -: 4], ir[25:0], 2'b00};

    assign mem_addr  = iord ? alu_out : pc;
    assign w_data    = b_reg;
    assign rf_w_data = mem_to_reg ? mdr : alu_out;

    assign alu_x = alu_src_a ? a_reg : pc;

    always_comb begin
        case (alu_src_b)
            mips_pkg::src_b_four:        alu_y = `MIPS_WORD_BYTES;
            mips_pkg::src_b_imm:         alu_y = sign_imm;
            mips_pkg::src_b_imm_shifted: alu_y = imm_shifted;
            default:                     alu_y = b_reg;
        endcase
    end

    always_comb begin
        case (pc_src)
            mips_pkg::pc_alu_out:     pc_next = alu_out;
            mips_pkg::pc_jump_target: pc_next = jump_target;
            default:                  pc_next = alu_result; // PC+4
        endcase
    end

    // beq taken on equal operands, bne on unequal
    assign take_branch = (branch_eq && alu_zero) || (branch_ne && !alu_zero);
    assign pc_en       = pc_write || take_branch;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (clk_en && pc_en) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (ir_write) begin
                ir <= r_data;
            end
            if (mdr_write) begin
                mdr <= r_data;
            end
            if (alu_out_write) begin
                alu_out <= alu_result;
            end
            a_reg <= rf_r0_data; // A and B follow the rs and rt fields on every enabled cycle
            b_reg <= rf_r1_data;
        end
    end

endmodule

`default_nettype wire

// File: design/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Word width of the datapath, memory bus and register file
`define MIPS_DATA_WIDTH 32

// Register index width of the five-bit rs, rt and rd fields
`define MIPS_REG_ADDR_WIDTH 5

// Number of architectural registers
`define MIPS_REG_COUNT 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// PC step per instruction
`define MIPS_WORD_BYTES 32'd4

`endif

// File: design/mips_cpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_cfg.svh"

module mips_cpu (
    input  wire logic                        clk,
    input  wire logic                        clk_en,
    input  wire logic                        reset,
    input  wire logic [`MIPS_DATA_WIDTH-1:0] r_data,   // Combinational read of mem_addr
    output logic                             wr_en,
    output logic [`MIPS_DATA_WIDTH-1:0]      mem_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]      w_data
);

    // Control levels valid for the whole current state
    logic pc_write;
    logic branch_eq;
    logic branch_ne;
    logic iord;
    logic ir_write;
    logic mdr_write;
    logic alu_out_write;
    logic reg_write;
    logic reg_dst;
    logic mem_to_reg;
    logic alu_src_a;
    mips_pkg::src_b_t  alu_src_b;
    mips_pkg::pc_src_t pc_src;
    mips_pkg::alu_op_t alu_op;

    mips_pkg::opcode_t opcode; // Decoded fields back to the FSM
    mips_pkg::funct_t  funct;

    // Register file ports
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rf_r0_addr;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rf_r1_addr;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rf_w_addr;
    logic [`MIPS_DATA_WIDTH-1:0]     rf_r0_data;
    logic [`MIPS_DATA_WIDTH-1:0]     rf_r1_data;
    logic [`MIPS_DATA_WIDTH-1:0]     rf_w_data;

    // ALU operands and result
    logic [`MIPS_DATA_WIDTH-1:0] alu_x;
    logic [`MIPS_DATA_WIDTH-1:0] alu_y;
    logic [`MIPS_DATA_WIDTH-1:0] alu_result;
    logic                        alu_zero;

    control_fsm ctrl_inst (
        .clk(clk), .clk_en(clk_en), .reset(reset),
        .opcode(opcode), .funct(funct),
        .pc_write(pc_write), .branch_eq(branch_eq), .branch_ne(branch_ne),
        .iord(iord), .ir_write(ir_write), .mdr_write(mdr_write),
        .alu_out_write(alu_out_write), .reg_write(reg_write),
        .reg_dst(reg_dst), .mem_to_reg(mem_to_reg),
        .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
        .pc_src(pc_src), .alu_op(alu_op), .wr_en(wr_en)
    );

    datapath datapath_inst (
        .clk(clk), .clk_en(clk_en), .reset(reset),
        .pc_write(pc_write), .branch_eq(branch_eq), .branch_ne(branch_ne),
        .iord(iord), .ir_write(ir_write), .mdr_write(mdr_write),
        .alu_out_write(alu_out_write), .reg_dst(reg_dst), .mem_to_reg(mem_to_reg),
        .alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .pc_src(pc_src),
        .r_data(r_data), .rf_r0_data(rf_r0_data), .rf_r1_data(rf_r1_data),
        .alu_result(alu_result), .alu_zero(alu_zero),
        .opcode(opcode), .funct(funct), .mem_addr(mem_addr), .w_data(w_data),
        .rf_r0_addr(rf_r0_addr), .rf_r1_addr(rf_r1_addr),
        .rf_w_addr(rf_w_addr), .rf_w_data(rf_w_data),
        .alu_x(alu_x), .alu_y(alu_y)
    );

    reg_file reg_file_inst (
        .clk(clk), .clk_en(clk_en), .reg_write(reg_write),
        .w_addr(rf_w_addr), .w_data(rf_w_data),
        .r0_addr(rf_r0_addr), .r1_addr(rf_r1_addr),
        .r0_data(rf_r0_data), .r1_data(rf_r1_data)
    );

    alu alu_inst (
        .x(alu_x), .y(alu_y), .op(alu_op),
        .z(alu_result), .zero(alu_zero)
    );

endmodule

`default_nettype wire

// File: design/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Multicycle control states
    typedef enum logic [3:0] {
        st_fetch         = 4'd0,
        st_decode        = 4'd1,
        st_mem_addr      = 4'd2,
        st_mem_read      = 4'd3,
        st_mem_writeback = 4'd4,
        st_mem_write     = 4'd5,
        st_r_execute     = 4'd6,
        st_r_writeback   = 4'd7,
        st_branch        = 4'd8,
        st_imm_execute   = 4'd9,
        st_imm_writeback = 4'd10,
        st_jump          = 4'd11
    } state_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    // MIPS32 primary opcodes in instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // R-type function field in instr[5:0]
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    typedef enum logic [1:0] {
        pc_alu_result  = 2'd0, // PC+4 straight from the ALU
        pc_alu_out     = 2'd1, // Branch target held since decode
        pc_jump_target = 2'd2
    } pc_src_t;

    typedef enum logic [1:0] {
        src_b_reg_b       = 2'd0,
        src_b_four        = 2'd1,
        src_b_imm         = 2'd2,
        src_b_imm_shifted = 2'd3
    } src_b_t;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_cfg.svh"

module reg_file (
    input  wire logic                            clk,
    input  wire logic                            clk_en,
    input  wire logic                            reg_write,
    input  wire logic [`MIPS_REG_ADDR_WIDTH-1:0] w_addr,
    input  wire logic [`MIPS_DATA_WIDTH-1:0]     w_data,
    input  wire logic [`MIPS_REG_ADDR_WIDTH-1:0] r0_addr,
    input  wire logic [`MIPS_REG_ADDR_WIDTH-1:0] r1_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]          r0_data,
    output logic [`MIPS_DATA_WIDTH-1:0]          r1_data
);

    logic [`MIPS_DATA_WIDTH-1:0] regs [`MIPS_REG_COUNT];

    // $zero is never written
    always_ff @(posedge clk) begin
        if (clk_en && reg_write && (w_addr != '0)) begin
            regs[w_addr] <= w_data;
        end
    end

    // Combinational reads with index 0 forced to zero
    assign r0_data = (r0_addr == '0) ? '0 : regs[r0_addr];
    assign r1_data = (r1_addr == '0) ? '0 : regs[r1_addr];

endmodule

`default_nettype wire

// File: testbench/mips_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_cfg.svh"

module mips_checker (
    input wire logic                        clk,
    input wire logic                        reset,
    input wire logic                        clk_en,
    input wire logic                        wr_en,
    input wire logic [`MIPS_DATA_WIDTH-1:0] mem_addr,
    input wire logic [`MIPS_DATA_WIDTH-1:0] w_data
);

    logic [31:0] ref_mem [256]; // Initial image of the program and data
    logic [31:0] exp_addr [$];  // Expected stores in program order
    logic [31:0] exp_data [$];
    string       test_name;
    int          store_idx;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        reset_q;

    initial begin
        test_name    = "none";
        store_idx    = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_q      = 1'b0;
    end

    task automatic load_word(input int idx, input logic [31:0] value);
        ref_mem[idx] = value;
    endtask

    task automatic report_problem(input string msg);
        $display("Error in %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic report_value(input string what, input logic [31:0] exp, act);
        $display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
        errors++;
    endtask

    // Instruction-set model that runs until a j to its own address
    function automatic logic run_reference();
        logic [31:0] regs [32];
        logic [31:0] dmem [256];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] target;
        int          i;
        for (i = 0; i < 256; i++) begin
            dmem[i] = ref_mem[i];
        end
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = `MIPS_RESET_PC;
        for (i = 0; i < 5000; i++) begin
            ir     = dmem[pc[9:2]];
            a      = regs[ir[25:21]];
            b      = regs[ir[20:16]];
            imm    = {{16{ir[15]}}, ir[15:0]}; // Always sign-extended
            ea     = a + imm;
            npc    = pc + `MIPS_WORD_BYTES;
            target = {npc[31:28], ir[25:0], 2'b00};
            case (ir[31:26])
                mips_pkg::op_rtype: begin
                    case (ir[5:0])
                        mips_pkg::fn_add: regs[ir[15:11]] = a + b;
                        mips_pkg::fn_sub: regs[ir[15:11]] = a - b;
                        mips_pkg::fn_and: regs[ir[15:11]] = a & b;
                        mips_pkg::fn_or:  regs[ir[15:11]] = a | b;
                        mips_pkg::fn_slt: regs[ir[15:11]] = {31'd0, $signed(a) < $signed(b)};
                        default: ;
                    endcase
                end
                mips_pkg::op_addi: regs[ir[20:16]] = ea;
                mips_pkg::op_lw:   regs[ir[20:16]] = dmem[ea[9:2]];
                mips_pkg::op_sw: begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                    dmem[ea[9:2]] = b;
                end
                mips_pkg::op_beq: begin
                    if (a == b) begin
                        npc = npc + (imm << 2);
                    end
                end
                mips_pkg::op_bne: begin
                    if (a != b) begin
                        npc = npc + (imm << 2);
                    end
                end
                mips_pkg::op_j: begin
                    if (target == pc) begin
                        return 1'b1;
                    end
                    npc = target;
                end
                default: ;
            endcase
            regs[0] = '0; // $zero
            pc = npc;
        end
        return 1'b0;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        exp_addr.delete();
        exp_data.delete();
        store_idx = 0;
        errors    = 0;
        if (!run_reference()) begin
            report_problem("reference model never reached the closing jump");
        end
    endtask

    task automatic finish_test();
        if (store_idx != exp_addr.size()) begin
            report_problem($sformatf("saw %0d stores, reference makes %0d",
                                     store_idx, exp_addr.size()));
        end
        tests_run++;
        if (errors == 0) begin
            $display("Test %s passed, %0d stores checked", test_name, store_idx);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, errors);
        end
    endtask

    task automatic print_summary();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
    endtask

    always @(posedge clk) begin
        reset_q <= reset;
        // First cycle out of reset is a fetch from the reset PC
        if (reset_q && !reset) begin
            if (mem_addr !== `MIPS_RESET_PC) begin
                report_value("first fetch address", `MIPS_RESET_PC, mem_addr);
            end
            if (wr_en !== 1'b0) begin
                report_problem("wr_en high on the first cycle after reset");
            end
        end
        if (!reset && wr_en === 1'b1) begin
            if (clk_en !== 1'b1) begin
                report_problem("store strobe on a cycle with clk_en low");
            end
            if (store_idx >= exp_addr.size()) begin
                report_problem($sformatf("unexpected store of %h to %h", w_data, mem_addr));
            end else begin
                if (mem_addr !== exp_addr[store_idx]) begin
                    report_value($sformatf("store %0d address", store_idx),
                                 exp_addr[store_idx], mem_addr);
                end
                if (w_data !== exp_data[store_idx]) begin
                    report_value($sformatf("store %0d data", store_idx),
                                 exp_data[store_idx], w_data);
                end
            end
            store_idx++;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_mips_cpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "mips_cfg.svh"

module tb_mips_cpu;

    logic                        clk;
    logic                        clk_en;
    logic                        reset;
    logic [`MIPS_DATA_WIDTH-1:0] r_data;
    logic                        wr_en;
    logic [`MIPS_DATA_WIDTH-1:0] mem_addr;
    logic [`MIPS_DATA_WIDTH-1:0] w_data;

    logic [31:0] mem [256];   // 1 KB addressed by word through mem_addr[9:2]
    logic [31:0] lfsr_state;
    logic        stall_mode;  // clk_en follows the LFSR
    logic [31:0] halt_pc;     // Address of the closing j to itself
    int          next_word;   // Next program slot
    logic [31:0] alu_d0;
    logic [31:0] alu_d1;

    mips_cpu UUT (
        .clk(clk), .clk_en(clk_en), .reset(reset), .r_data(r_data),
        .wr_en(wr_en), .mem_addr(mem_addr), .w_data(w_data)
    );

    mips_checker chk (
        .clk(clk), .reset(reset), .clk_en(clk_en),
        .wr_en(wr_en), .mem_addr(mem_addr), .w_data(w_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    assign r_data = mem[mem_addr[9:2]]; // Combinational read

    always @(posedge clk) begin
        if (wr_en) begin
            mem[mem_addr[9:2]] <= w_data;
        end
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always @(negedge clk) begin
        if (stall_mode) begin
            clk_en = lfsr_state[0]; // One bit per cycle
            lfsr_state = next_lfsr(lfsr_state);
        end else begin
            clk_en = 1'b1;
        end
    end

    task automatic random_word(output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < 32; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    task automatic put_word(input int idx, input logic [31:0] value);
        mem[idx] = value;
        chk.load_word(idx, value); // Reference model gets the same image
    endtask

    // Reset goes high and memory gets a pattern unique to each word
    task automatic start_program();
        int i;
        @(negedge clk);
        reset = 1'b1;
        for (i = 0; i < 256; i++) begin
            put_word(i, 32'hc35a_0000 ^ (i << 8) ^ i);
        end
        next_word = 0;
    endtask

    task automatic emit(input logic [31:0] instr);
        put_word(next_word, instr);
        next_word++;
    endtask

    task automatic emit_r(input mips_pkg::funct_t fn, input logic [4:0] rd, rs, rt);
        emit({mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn});
    endtask

    // Field order as encoded with rs before rt
    task automatic emit_i(input mips_pkg::opcode_t op, input logic [4:0] rs, rt,
                          input logic [15:0] imm);
        emit({op, rs, rt, imm});
    endtask

    task automatic emit_halt();
        halt_pc = next_word * 4;
        emit({mips_pkg::op_j, halt_pc[27:2]});
    endtask

    task automatic load_alu_program(input logic [31:0] d0, d1);
        int r;
        put_word(64, d0); // 0x100
        put_word(65, d1); // 0x104
        emit_i(mips_pkg::op_lw, 0, 1, 16'h0100);
        emit_i(mips_pkg::op_lw, 0, 2, 16'h0104);
        emit_r(mips_pkg::fn_add, 3, 1, 2);
        emit_r(mips_pkg::fn_sub, 4, 1, 2);
        emit_r(mips_pkg::fn_and, 5, 1, 2);
        emit_r(mips_pkg::fn_or, 6, 1, 2);
        emit_r(mips_pkg::fn_slt, 7, 1, 2);
        emit_r(mips_pkg::fn_slt, 8, 2, 1);            // Both compare orders
        emit_i(mips_pkg::op_addi, 1, 9, 16'hfffd);    // Negative immediate
        emit_i(mips_pkg::op_addi, 2, 10, 16'h1234);
        for (r = 3; r <= 10; r++) begin
            emit_i(mips_pkg::op_sw, 0, r, 16'(16'h0200 + 4 * r));
        end
        emit_halt();
    endtask

    task automatic load_copy_program();
        logic [31:0] d;
        int          k;
        emit_i(mips_pkg::op_addi, 0, 20, 16'h0300); // Destination base
        for (k = 0; k < 6; k++) begin
            random_word(d);
            put_word(80 + k, d); // Sources from 0x140
            emit_i(mips_pkg::op_lw, 0, 11 + k, 16'(16'h0140 + 4 * k));
            emit_i(mips_pkg::op_sw, 20, 11 + k, 16'(16'h0020 - 8 * k)); // Ends below base
        end
        emit_halt();
    endtask

    task automatic load_branch_program();
        int loop_at;
        emit_i(mips_pkg::op_addi, 0, 1, 16'd5);
        emit_i(mips_pkg::op_addi, 0, 2, 16'd5);
        emit_i(mips_pkg::op_addi, 0, 3, 16'd7);
        emit_i(mips_pkg::op_beq, 1, 2, 16'd1);        // Taken
        emit_i(mips_pkg::op_sw, 0, 1, 16'h0280);
        emit_i(mips_pkg::op_sw, 0, 2, 16'h0284);
        emit_i(mips_pkg::op_beq, 1, 3, 16'd1);        // Falls through
        emit_i(mips_pkg::op_sw, 0, 3, 16'h0288);
        emit_i(mips_pkg::op_bne, 1, 3, 16'd1);        // Taken
        emit_i(mips_pkg::op_sw, 0, 1, 16'h028c);
        emit_i(mips_pkg::op_bne, 1, 2, 16'd1);        // Falls through
        emit_i(mips_pkg::op_sw, 0, 2, 16'h0290);
        emit({mips_pkg::op_j, 26'(next_word + 2)});   // Hops one store
        emit_i(mips_pkg::op_sw, 0, 3, 16'h0294);
        emit_i(mips_pkg::op_addi, 0, 4, 16'd3);
        emit_i(mips_pkg::op_addi, 0, 5, 16'h02a0);
        loop_at = next_word;
        emit_i(mips_pkg::op_addi, 4, 4, 16'hffff);    // Count down
        emit_i(mips_pkg::op_sw, 5, 4, 16'h0000);
        emit_i(mips_pkg::op_addi, 5, 5, 16'd4);
        emit_i(mips_pkg::op_bne, 4, 0, 16'(loop_at - next_word - 1)); // Backward
        emit_halt();
    endtask

    task automatic load_zero_program();
        emit_i(mips_pkg::op_addi, 0, 0, 16'h0055);    // Dropped write
        emit_i(mips_pkg::op_sw, 0, 0, 16'h02c0);
        emit_i(mips_pkg::op_lw, 0, 0, 16'h0100);
        emit_i(mips_pkg::op_sw, 0, 0, 16'h02c4);
        emit_i(mips_pkg::op_addi, 0, 1, 16'd9);       // Reads $zero as zero
        emit_r(mips_pkg::fn_add, 0, 1, 1);
        emit_i(mips_pkg::op_sw, 0, 0, 16'h02c8);
        emit_i(mips_pkg::op_sw, 0, 1, 16'h02cc);
        emit_halt();
    endtask

    // Three reset cycles and a run until PC has moved past the closing jump
    task automatic run_test(input string name, input logic stall, input int limit);
        int          n;
        logic [31:0] done_addr;
        done_addr = halt_pc + `MIPS_WORD_BYTES; // PC only gets here once the halt is fetched
        chk.start_test(name);
        repeat (3) @(posedge clk);
        stall_mode = stall;
        @(negedge clk);
        reset = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (mem_addr !== done_addr && n < limit);
        if (mem_addr !== done_addr) begin
            chk.report_problem($sformatf("PC did not pass the closing jump at %h within %0d cycles",
                                         halt_pc, limit));
        end
        @(posedge clk);
        stall_mode = 1'b0;
        chk.finish_test();
    endtask

    initial begin
        clk_en     = 1'b1;
        reset      = 1'b1;
        stall_mode = 1'b0;
        lfsr_state = 32'ha45e_9b47;
        halt_pc    = `MIPS_RESET_PC;
        next_word  = 0;

        start_program();
        emit_i(mips_pkg::op_addi, 0, 0, 16'd0); // A few idle instructions without stores
        emit_i(mips_pkg::op_addi, 0, 0, 16'd0);
        emit_halt();
        run_test("reset", 1'b0, 200);

        start_program();
        random_word(alu_d0);
        random_word(alu_d1);
        load_alu_program(alu_d0, alu_d1);
        run_test("alu_ops", 1'b0, 1000);

        start_program();
        load_copy_program();
        run_test("copy", 1'b0, 1000);

        start_program();
        load_branch_program();
        run_test("branches", 1'b0, 1000);

        start_program();
        load_zero_program();
        run_test("zero_reg", 1'b0, 1000);

        start_program();
        load_alu_program(alu_d0, alu_d1); // Same data as before
        run_test("alu_ops_stalled", 1'b1, 4000);

        chk.print_summary();
        if (chk.tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/mips_pkg.sv
design/alu.sv
design/reg_file.sv
design/control_fsm.sv
design/datapath.sv
design/mips_cpu.sv
testbench/mips_checker.sv
testbench/tb_mips_cpu.sv
